// File: hw/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// ============================================================
// Datapath and buffering.
// ============================================================
`define EXU_XLEN        32
`define EXU_IN_CREDITS  2
`define EXU_MEM_CREDITS 2
`define EXU_OUT_CREDITS 2
`define EXU_DMEM_WORDS  64   // Word entries, power of two.

// ============================================================
// Machine-mode CSRs.
// ============================================================
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

`define EXU_CAUSE_ECALL 32'd11  // Environment call from M-mode.

`endif

// File: hw/exu_pkg.sv
package exu_pkg;

  // Operation class as set by the decoder.
  typedef enum logic [2:0] {
    OP_ALU,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LOAD,
    OP_STORE,
    OP_SYSTEM
  } op_class_e;

  // ALU function, also carries the branch condition.
  typedef enum logic [3:0] {
    ADD,
    SUB,    // beq: taken on zero.
    AND,
    OR,
    XOR,    // bne: taken on nonzero.
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    SGE,
    SGEU
  } alu_op_e;

  // System function.
  typedef enum logic [2:0] {
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_CSRRC,
    SYS_ECALL,
    SYS_EBREAK,
    SYS_MRET
  } sys_op_e;

endpackage

// File: hw/exu_alu.sv
`include "exu_defs.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  exu_pkg::alu_op_e     op_i,
  output logic [`EXU_XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic       cmp;

  assign shamt = b_i[4:0];

  // Compare result for the set and branch functions.
  always_comb begin
    cmp = 1'b0;
    case (op_i)
      exu_pkg::SLT:  cmp = $signed(a_i) < $signed(b_i);
      exu_pkg::SLTU: cmp = a_i < b_i;
      exu_pkg::SGE:  cmp = $signed(a_i) >= $signed(b_i);
      exu_pkg::SGEU: cmp = a_i >= b_i;
      default:       cmp = 1'b0;
    endcase
  end

  always_comb begin
    case (op_i)
      exu_pkg::ADD: res_o = a_i + b_i;
      exu_pkg::SUB: res_o = a_i - b_i;
      exu_pkg::AND: res_o = a_i & b_i;
      exu_pkg::OR:  res_o = a_i | b_i;
      exu_pkg::XOR: res_o = a_i ^ b_i;
      exu_pkg::SLL: res_o = a_i << shamt;
      exu_pkg::SRL: res_o = a_i >> shamt;
      exu_pkg::SRA: res_o = $unsigned($signed(a_i) >>> shamt);
      exu_pkg::SLT,
      exu_pkg::SLTU,
      exu_pkg::SGE,
      exu_pkg::SGEU: res_o = {{(`EXU_XLEN-1){1'b0}}, cmp};
      default:      res_o = '0;
    endcase
  end

endmodule

// File: hw/exu_csr_file.sv
`include "exu_defs.svh"

module exu_csr_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [11:0]          addr_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  input  logic                 wen_i,
  input  logic [`EXU_XLEN-1:0] wdata_i,
  input  logic                 trap_i,
  input  logic [`EXU_XLEN-1:0] trap_pc_i,
  input  logic                 mret_i,
  output logic [`EXU_XLEN-1:0] mtvec_o,
  output logic [`EXU_XLEN-1:0] mepc_o
);

  logic [`EXU_XLEN-1:0] mstatus;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mcause;

  // Read port, unmapped addresses return zero.
  always_comb begin
    case (addr_i)
      `EXU_CSR_MSTATUS: rdata_o = mstatus;
      `EXU_CSR_MTVEC:   rdata_o = mtvec;
      `EXU_CSR_MEPC:    rdata_o = mepc;
      `EXU_CSR_MCAUSE:  rdata_o = mcause;
      default:          rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (trap_i) begin
      mepc   <= trap_pc_i;
      mcause <= `EXU_CAUSE_ECALL;
    end else if (mret_i) begin
      mstatus[3] <= mstatus[7];  // MIE from MPIE.
      mstatus[7] <= 1'b1;
    end else if (wen_i) begin
      case (addr_i)
        `EXU_CSR_MSTATUS: mstatus <= wdata_i;
        `EXU_CSR_MTVEC:   mtvec   <= wdata_i;
        `EXU_CSR_MEPC:    mepc    <= wdata_i;
        `EXU_CSR_MCAUSE:  mcause  <= wdata_i;
        default: ;
      endcase
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

  // The execute stage issues at most one system op per cycle.
  a_one_update: assert property (@(posedge clk) disable iff (rst)
    $onehot0({trap_i, mret_i, wen_i}))
    else $error("CSR trap, mret and write active together");

endmodule

// File: hw/exu_execute.sv
`include "exu_defs.svh"

module exu_execute (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 op_valid_i,
  output logic                 op_credit_o,
  input  exu_pkg::op_class_e   op_class_i,
  input  exu_pkg::alu_op_e     alu_op_i,
  input  exu_pkg::sys_op_e     sys_op_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  input  logic [`EXU_XLEN-1:0] imm_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [4:0]           rd_i,
  input  logic [11:0]          csr_addr_i,
  output logic                 ex_valid_o,
  output logic [4:0]           ex_rd_o,
  output logic                 ex_wen_o,
  output logic [`EXU_XLEN-1:0] ex_result_o,
  output logic [`EXU_XLEN-1:0] ex_store_data_o,
  output logic [`EXU_XLEN-1:0] ex_addr_o,
  output logic [`EXU_XLEN-1:0] ex_npc_o,
  output logic                 ex_load_o,
  output logic                 ex_store_o,
  output logic                 ex_ebreak_o,
  input  logic                 mem_credit_i
);

  localparam int DEPTH = `EXU_IN_CREDITS;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);
  localparam int MW    = $clog2(`EXU_MEM_CREDITS + 1);

  exu_pkg::op_class_e   q_class [DEPTH];
  exu_pkg::alu_op_e     q_alu   [DEPTH];
  exu_pkg::sys_op_e     q_sys   [DEPTH];
  logic [`EXU_XLEN-1:0] q_src1  [DEPTH];
  logic [`EXU_XLEN-1:0] q_src2  [DEPTH];
  logic [`EXU_XLEN-1:0] q_imm   [DEPTH];
  logic [`EXU_XLEN-1:0] q_pc    [DEPTH];
  logic [4:0]           q_rd    [DEPTH];
  logic [11:0]          q_csr   [DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [MW-1:0] mem_cnt;   // Free slots in the memory stage.
  logic          issue;

  exu_pkg::op_class_e   h_class;
  exu_pkg::alu_op_e     h_alu;
  exu_pkg::sys_op_e     h_sys;
  logic [`EXU_XLEN-1:0] h_src1, h_src2, h_imm, h_pc;

  logic [`EXU_XLEN-1:0] alu_res, pc_plus4, ea, npc, result;
  logic [`EXU_XLEN-1:0] csr_rdata, csr_wdata, mtvec, mepc;
  logic is_csr, is_ecall, is_mret, is_ebreak, taken, wen;

  // ============================================================
  // Input FIFO.
  // ============================================================
  always_ff @(posedge clk) begin
    if (op_valid_i) begin
      q_class[wr_ptr] <= op_class_i;
      q_alu[wr_ptr]   <= alu_op_i;
      q_sys[wr_ptr]   <= sys_op_i;
      q_src1[wr_ptr]  <= src1_i;
      q_src2[wr_ptr]  <= src2_i;
      q_imm[wr_ptr]   <= imm_i;
      q_pc[wr_ptr]    <= pc_i;
      q_rd[wr_ptr]    <= rd_i;
      q_csr[wr_ptr]   <= csr_addr_i;
    end
  end

  assign h_class = q_class[rd_ptr];
  assign h_alu   = q_alu[rd_ptr];
  assign h_sys   = q_sys[rd_ptr];
  assign h_src1  = q_src1[rd_ptr];
  assign h_src2  = q_src2[rd_ptr];
  assign h_imm   = q_imm[rd_ptr];
  assign h_pc    = q_pc[rd_ptr];

  assign issue = (count != '0) && (mem_cnt != '0);

  // ============================================================
  // Branch, jump and system resolution on the FIFO head.
  // ============================================================
  exu_alu i_alu (
    .a_i   (h_src1),
    .b_i   (h_src2),
    .op_i  (h_alu),
    .res_o (alu_res)
  );

  assign pc_plus4  = h_pc + `EXU_XLEN'(4);
  assign ea        = h_src1 + h_imm;
  assign is_csr    = (h_class == exu_pkg::OP_SYSTEM) &&
                     (h_sys inside {exu_pkg::SYS_CSRRW, exu_pkg::SYS_CSRRS, exu_pkg::SYS_CSRRC});
  assign is_ecall  = (h_class == exu_pkg::OP_SYSTEM) && (h_sys == exu_pkg::SYS_ECALL);
  assign is_mret   = (h_class == exu_pkg::OP_SYSTEM) && (h_sys == exu_pkg::SYS_MRET);
  assign is_ebreak = (h_class == exu_pkg::OP_SYSTEM) && (h_sys == exu_pkg::SYS_EBREAK);
  assign taken     = (h_alu == exu_pkg::SUB) ? (alu_res == '0) : (alu_res != '0);

  always_comb begin
    case (h_sys)
      exu_pkg::SYS_CSRRS: csr_wdata = csr_rdata | h_src1;
      exu_pkg::SYS_CSRRC: csr_wdata = csr_rdata & ~h_src1;
      default:            csr_wdata = h_src1;
    endcase
  end

  always_comb begin
    npc    = pc_plus4;
    result = alu_res;
    case (h_class)
      exu_pkg::OP_BRANCH: if (taken) npc = h_pc + h_imm;
      exu_pkg::OP_JAL: begin
        npc    = h_pc + h_imm;
        result = pc_plus4;
      end
      exu_pkg::OP_JALR: begin
        npc    = {ea[`EXU_XLEN-1:1], 1'b0};
        result = pc_plus4;
      end
      exu_pkg::OP_LOAD, exu_pkg::OP_STORE: result = ea;
      exu_pkg::OP_SYSTEM: begin
        result = csr_rdata;  // Old value for CSR ops.
        if (is_ecall) npc = mtvec;
        else if (is_mret) npc = mepc;
      end
      default: ;
    endcase
  end

  assign wen = (q_rd[rd_ptr] != 5'd0) && (is_csr ||
               (h_class inside {exu_pkg::OP_ALU, exu_pkg::OP_JAL, exu_pkg::OP_JALR,
                                exu_pkg::OP_LOAD}));

  exu_csr_file i_csr_file (
    .clk       (clk),
    .rst       (rst),
    .addr_i    (q_csr[rd_ptr]),
    .rdata_o   (csr_rdata),
    .wen_i     (issue && is_csr),
    .wdata_i   (csr_wdata),
    .trap_i    (issue && is_ecall),
    .trap_pc_i (h_pc),
    .mret_i    (issue && is_mret),
    .mtvec_o   (mtvec),
    .mepc_o    (mepc)
  );

  // ============================================================
  // Control and credits.
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      mem_cnt     <= MW'(`EXU_MEM_CREDITS);
      op_credit_o <= 1'b0;
      ex_valid_o  <= 1'b0;
    end else begin
      if (op_valid_i) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (issue) rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({op_valid_i, issue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      case ({issue, mem_credit_i})
        2'b10:   mem_cnt <= mem_cnt - 1'b1;
        2'b01:   mem_cnt <= mem_cnt + 1'b1;
        default: ;
      endcase
      op_credit_o <= issue;
      ex_valid_o  <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      ex_rd_o         <= q_rd[rd_ptr];
      ex_wen_o        <= wen;
      ex_result_o     <= result;
      ex_store_data_o <= h_src2;
      ex_addr_o       <= ea;
      ex_npc_o        <= npc;
      ex_load_o       <= (h_class == exu_pkg::OP_LOAD);
      ex_store_o      <= (h_class == exu_pkg::OP_STORE);
      ex_ebreak_o     <= is_ebreak;
    end
  end

  // Upstream must hold a credit for every op it sends.
  a_in_no_overflow: assert property (@(posedge clk) disable iff (rst)
    op_valid_i |-> (count < CW'(DEPTH)))
    else $error("Execute input FIFO written while full");

  a_mem_credit_bound: assert property (@(posedge clk) disable iff (rst)
    mem_cnt <= MW'(`EXU_MEM_CREDITS))
    else $error("Memory stage credits above reset value");

endmodule

// File: hw/exu_mem_stage.sv
`include "exu_defs.svh"

module exu_mem_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ex_valid_i,
  input  logic [4:0]           ex_rd_i,
  input  logic                 ex_wen_i,
  input  logic [`EXU_XLEN-1:0] ex_result_i,
  input  logic [`EXU_XLEN-1:0] ex_store_data_i,
  input  logic [`EXU_XLEN-1:0] ex_addr_i,
  input  logic [`EXU_XLEN-1:0] ex_npc_i,
  input  logic                 ex_load_i,
  input  logic                 ex_store_i,
  input  logic                 ex_ebreak_i,
  output logic                 mem_credit_o,
  output logic                 wb_valid_o,
  output logic [4:0]           wb_rd_o,
  output logic                 wb_wen_o,
  output logic [`EXU_XLEN-1:0] wb_data_o,
  output logic [`EXU_XLEN-1:0] wb_npc_o,
  output logic                 wb_ebreak_o,
  input  logic                 wb_credit_i
);

  localparam int DEPTH = `EXU_MEM_CREDITS;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);
  localparam int OW    = $clog2(`EXU_OUT_CREDITS + 1);
  localparam int AW    = $clog2(`EXU_DMEM_WORDS);

  logic [4:0]           q_rd     [DEPTH];
  logic                 q_wen    [DEPTH];
  logic [`EXU_XLEN-1:0] q_result [DEPTH];
  logic [`EXU_XLEN-1:0] q_sdata  [DEPTH];
  logic [`EXU_XLEN-1:0] q_addr   [DEPTH];
  logic [`EXU_XLEN-1:0] q_npc    [DEPTH];
  logic                 q_load   [DEPTH];
  logic                 q_store  [DEPTH];
  logic                 q_ebreak [DEPTH];

  logic [`EXU_XLEN-1:0] dmem [`EXU_DMEM_WORDS];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [OW-1:0] out_cnt;   // Credits held toward the consumer.
  logic [AW-1:0] widx;
  logic          pop;

  // ============================================================
  // Record FIFO.
  // ============================================================
  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      q_rd[wr_ptr]     <= ex_rd_i;
      q_wen[wr_ptr]    <= ex_wen_i;
      q_result[wr_ptr] <= ex_result_i;
      q_sdata[wr_ptr]  <= ex_store_data_i;
      q_addr[wr_ptr]   <= ex_addr_i;
      q_npc[wr_ptr]    <= ex_npc_i;
      q_load[wr_ptr]   <= ex_load_i;
      q_store[wr_ptr]  <= ex_store_i;
      q_ebreak[wr_ptr] <= ex_ebreak_i;
    end
  end

  assign pop  = (count != '0) && (out_cnt != '0);
  assign widx = q_addr[rd_ptr][AW+1:2];  // Word index wraps with the memory size.

  // ============================================================
  // Data memory and writeback.
  // ============================================================
  always_ff @(posedge clk) begin
    if (pop && q_store[rd_ptr]) dmem[widx] <= q_sdata[rd_ptr];
  end

  assign wb_valid_o  = pop;
  assign wb_rd_o     = q_rd[rd_ptr];
  assign wb_wen_o    = q_wen[rd_ptr];
  assign wb_data_o   = q_load[rd_ptr] ? dmem[widx] : q_result[rd_ptr];
  assign wb_npc_o    = q_npc[rd_ptr];
  assign wb_ebreak_o = q_ebreak[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      out_cnt      <= OW'(`EXU_OUT_CREDITS);
      mem_credit_o <= 1'b0;
    end else begin
      if (ex_valid_i) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({ex_valid_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      case ({pop, wb_credit_i})
        2'b10:   out_cnt <= out_cnt - 1'b1;
        2'b01:   out_cnt <= out_cnt + 1'b1;
        default: ;
      endcase
      mem_credit_o <= pop;  // Slot freed, return it to execute.
    end
  end

  // Execute only issues against a credit from this stage.
  a_mem_no_overflow: assert property (@(posedge clk) disable iff (rst)
    ex_valid_i |-> (count < CW'(DEPTH)))
    else $error("Memory stage FIFO written while full");

  a_out_credit_bound: assert property (@(posedge clk) disable iff (rst)
    out_cnt <= OW'(`EXU_OUT_CREDITS))
    else $error("Consumer returned more credits than it was given");

endmodule

// File: hw/exu_top.sv
`include "exu_defs.svh"

module exu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 op_valid_i,
  output logic                 op_credit_o,
  input  exu_pkg::op_class_e   op_class_i,
  input  exu_pkg::alu_op_e     alu_op_i,
  input  exu_pkg::sys_op_e     sys_op_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  input  logic [`EXU_XLEN-1:0] imm_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [4:0]           rd_i,
  input  logic [11:0]          csr_addr_i,
  output logic                 wb_valid_o,
  output logic [4:0]           wb_rd_o,
  output logic                 wb_wen_o,
  output logic [`EXU_XLEN-1:0] wb_data_o,
  output logic [`EXU_XLEN-1:0] wb_npc_o,
  output logic                 wb_ebreak_o,
  input  logic                 wb_credit_i
);

  // Execute to memory stage record.
  logic                 ex_valid;
  logic [4:0]           ex_rd;
  logic                 ex_wen;
  logic [`EXU_XLEN-1:0] ex_result;
  logic [`EXU_XLEN-1:0] ex_store_data;
  logic [`EXU_XLEN-1:0] ex_addr;
  logic [`EXU_XLEN-1:0] ex_npc;
  logic                 ex_load;
  logic                 ex_store;
  logic                 ex_ebreak;
  logic                 mem_credit;

  exu_execute i_execute (
    .clk             (clk),
    .rst             (rst),
    .op_valid_i      (op_valid_i),
    .op_credit_o     (op_credit_o),
    .op_class_i      (op_class_i),
    .alu_op_i        (alu_op_i),
    .sys_op_i        (sys_op_i),
    .src1_i          (src1_i),
    .src2_i          (src2_i),
    .imm_i           (imm_i),
    .pc_i            (pc_i),
    .rd_i            (rd_i),
    .csr_addr_i      (csr_addr_i),
    .ex_valid_o      (ex_valid),
    .ex_rd_o         (ex_rd),
    .ex_wen_o        (ex_wen),
    .ex_result_o     (ex_result),
    .ex_store_data_o (ex_store_data),
    .ex_addr_o       (ex_addr),
    .ex_npc_o        (ex_npc),
    .ex_load_o       (ex_load),
    .ex_store_o      (ex_store),
    .ex_ebreak_o     (ex_ebreak),
    .mem_credit_i    (mem_credit)
  );

  exu_mem_stage i_mem_stage (
    .clk             (clk),
    .rst             (rst),
    .ex_valid_i      (ex_valid),
    .ex_rd_i         (ex_rd),
    .ex_wen_i        (ex_wen),
    .ex_result_i     (ex_result),
    .ex_store_data_i (ex_store_data),
    .ex_addr_i       (ex_addr),
    .ex_npc_i        (ex_npc),
    .ex_load_i       (ex_load),
    .ex_store_i      (ex_store),
    .ex_ebreak_i     (ex_ebreak),
    .mem_credit_o    (mem_credit),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_wen_o        (wb_wen_o),
    .wb_data_o       (wb_data_o),
    .wb_npc_o        (wb_npc_o),
    .wb_ebreak_o     (wb_ebreak_o),
    .wb_credit_i     (wb_credit_i)
  );

endmodule

// File: sim/tb_exu_top.sv
`include "exu_defs.svh"

module tb_exu_top;

  localparam int TOTAL_OPS  = 120;  // Upper bound on ops over all tests.
  localparam int WDOG_TICKS = TOTAL_OPS * 40 + 200;

  typedef struct packed {
    logic [4:0]  rd;
    logic        wen;
    logic        care;    // Data field is compared.
    logic [31:0] data;
    logic [31:0] npc;
    logic        ebreak;
  } wb_rec_t;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 op_valid_i;
  logic                 op_credit_o;
  exu_pkg::op_class_e   op_class_i;
  exu_pkg::alu_op_e     alu_op_i;
  exu_pkg::sys_op_e     sys_op_i;
  logic [`EXU_XLEN-1:0] src1_i;
  logic [`EXU_XLEN-1:0] src2_i;
  logic [`EXU_XLEN-1:0] imm_i;
  logic [`EXU_XLEN-1:0] pc_i;
  logic [4:0]           rd_i;
  logic [11:0]          csr_addr_i;
  logic                 wb_valid_o;
  logic [4:0]           wb_rd_o;
  logic                 wb_wen_o;
  logic [`EXU_XLEN-1:0] wb_data_o;
  logic [`EXU_XLEN-1:0] wb_npc_o;
  logic                 wb_ebreak_o;
  logic                 wb_credit_i = 1'b0;

  wb_rec_t     exp_q [$];
  int          sent_cnt = 0;
  int          ret_cnt = 0;
  int          got_cnt = 0;
  int          owed = 0;        // Consumer credits not yet returned.
  logic        hold_credits = 1'b0;
  logic [31:0] rng = 32'd74;
  logic [31:0] pc_seq = 32'h1000;
  logic [31:0] dmem_ref [`EXU_DMEM_WORDS];
  logic [31:0] mstatus_ref = '0;
  logic [31:0] mtvec_ref = '0;
  logic [31:0] mepc_ref = '0;
  logic [31:0] mcause_ref = '0;

  always #10 clk = ~clk;

  exu_top i_exu_top (.*);

  // ============================================================
  // Helpers and reference model.
  // ============================================================
  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic logic [31:0] next_pc();
    pc_seq += 32'd4;
    return pc_seq;
  endfunction

  function automatic int credits_left();
    return `EXU_IN_CREDITS + ret_cnt - sent_cnt;
  endfunction

  function automatic logic [31:0] alu_ref(input exu_pkg::alu_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [63:0] ext;
    logic        lt_s;
    ext  = {{32{a[31]}}, a} >> b[4:0];
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);  // Signed order via sign flip.
    case (op)
      exu_pkg::ADD:  return a + b;
      exu_pkg::SUB:  return a - b;
      exu_pkg::AND:  return a & b;
      exu_pkg::OR:   return a | b;
      exu_pkg::XOR:  return a ^ b;
      exu_pkg::SLL:  return a << b[4:0];
      exu_pkg::SRL:  return a >> b[4:0];
      exu_pkg::SRA:  return ext[31:0];
      exu_pkg::SLT:  return {31'b0, lt_s};
      exu_pkg::SLTU: return {31'b0, a < b};
      exu_pkg::SGE:  return {31'b0, !lt_s};
      exu_pkg::SGEU: return {31'b0, a >= b};
      default:       return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] csr_ref_read(input logic [11:0] addr);
    case (addr)
      `EXU_CSR_MSTATUS: return mstatus_ref;
      `EXU_CSR_MTVEC:   return mtvec_ref;
      `EXU_CSR_MEPC:    return mepc_ref;
      `EXU_CSR_MCAUSE:  return mcause_ref;
      default:          return 32'h0;
    endcase
  endfunction

  task automatic expect_wb(input logic [4:0] rd, input logic wen, input logic care,
                           input logic [31:0] data, input logic [31:0] npc,
                           input logic ebreak);
    exp_q.push_back({rd, wen, care, data, npc, ebreak});
  endtask

  // Waits for an upstream credit, then drives one op for a single cycle.
  task automatic send_op(input exu_pkg::op_class_e cls, input exu_pkg::alu_op_e aop,
                         input exu_pkg::sys_op_e sop, input logic [31:0] s1,
                         input logic [31:0] s2, input logic [31:0] imm,
                         input logic [31:0] pc, input logic [4:0] rd,
                         input logic [11:0] csr);
    @(posedge clk);
    while (credits_left() == 0) begin
      op_valid_i <= 1'b0;
      @(posedge clk);
    end
    op_valid_i <= 1'b1;
    op_class_i <= cls;
    alu_op_i   <= aop;
    sys_op_i   <= sop;
    src1_i     <= s1;
    src2_i     <= s2;
    imm_i      <= imm;
    pc_i       <= pc;
    rd_i       <= rd;
    csr_addr_i <= csr;
    sent_cnt++;
  endtask

  task automatic end_ops();
    @(posedge clk);
    op_valid_i <= 1'b0;
  endtask

  task automatic wait_idle();
    end_ops();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic run_alu(input exu_pkg::alu_op_e op, input logic [31:0] a,
                         input logic [31:0] b, input logic [4:0] rd);
    logic [31:0] pc;
    pc = next_pc();
    expect_wb(rd, rd != 5'd0, 1'b1, alu_ref(op, a, b), pc + 32'd4, 1'b0);
    send_op(exu_pkg::OP_ALU, op, exu_pkg::SYS_CSRRW, a, b, 32'h0, pc, rd, 12'h0);
  endtask

  task automatic run_branch(input exu_pkg::alu_op_e op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] imm);
    logic [31:0] pc;
    logic        taken;
    pc = next_pc();
    case (op)
      exu_pkg::SUB: taken = (a == b);
      exu_pkg::XOR: taken = (a != b);
      default:      taken = (alu_ref(op, a, b) != 32'h0);
    endcase
    expect_wb(5'd5, 1'b0, 1'b0, 32'h0, taken ? pc + imm : pc + 32'd4, 1'b0);
    send_op(exu_pkg::OP_BRANCH, op, exu_pkg::SYS_CSRRW, a, b, imm, pc, 5'd5, 12'h0);
  endtask

  task automatic run_jump(input exu_pkg::op_class_e cls, input logic [31:0] s1,
                          input logic [31:0] imm, input logic [4:0] rd);
    logic [31:0] pc;
    logic [31:0] tgt;
    pc  = next_pc();
    tgt = (cls == exu_pkg::OP_JAL) ? pc + imm : (s1 + imm) & ~32'd1;
    expect_wb(rd, rd != 5'd0, 1'b1, pc + 32'd4, tgt, 1'b0);
    send_op(cls, exu_pkg::ADD, exu_pkg::SYS_CSRRW, s1, 32'h0, imm, pc, rd, 12'h0);
  endtask

  task automatic mem_access(input logic store, input logic [31:0] base,
                            input logic [31:0] off, input logic [31:0] data,
                            input logic [4:0] rd);
    logic [31:0] pc;
    logic [31:0] ea;
    int          idx;
    pc  = next_pc();
    ea  = base + off;
    idx = (ea >> 2) % `EXU_DMEM_WORDS;
    if (store) begin
      dmem_ref[idx] = data;
      expect_wb(rd, 1'b0, 1'b1, ea, pc + 32'd4, 1'b0);
      send_op(exu_pkg::OP_STORE, exu_pkg::ADD, exu_pkg::SYS_CSRRW, base, data, off, pc,
              rd, 12'h0);
    end else begin
      expect_wb(rd, rd != 5'd0, 1'b1, dmem_ref[idx], pc + 32'd4, 1'b0);
      send_op(exu_pkg::OP_LOAD, exu_pkg::ADD, exu_pkg::SYS_CSRRW, base, 32'h0, off, pc,
              rd, 12'h0);
    end
  endtask

  task automatic csr_access(input exu_pkg::sys_op_e sop, input logic [11:0] addr,
                            input logic [31:0] val, input logic [4:0] rd);
    logic [31:0] pc;
    logic [31:0] old;
    logic [31:0] nxt;
    pc  = next_pc();
    old = csr_ref_read(addr);
    case (sop)
      exu_pkg::SYS_CSRRS: nxt = old | val;
      exu_pkg::SYS_CSRRC: nxt = old & ~val;
      default:            nxt = val;
    endcase
    case (addr)
      `EXU_CSR_MSTATUS: mstatus_ref = nxt;
      `EXU_CSR_MTVEC:   mtvec_ref = nxt;
      `EXU_CSR_MEPC:    mepc_ref = nxt;
      `EXU_CSR_MCAUSE:  mcause_ref = nxt;
      default: ;
    endcase
    expect_wb(rd, rd != 5'd0, 1'b1, old, pc + 32'd4, 1'b0);
    send_op(exu_pkg::OP_SYSTEM, exu_pkg::ADD, sop, val, 32'h0, 32'h0, pc, rd, addr);
  endtask

  // ecall, mret and ebreak. None of them writes a register.
  task automatic sys_event(input exu_pkg::sys_op_e sop);
    logic [31:0] pc;
    logic [31:0] npc;
    pc  = next_pc();
    npc = pc + 32'd4;
    if (sop == exu_pkg::SYS_ECALL) begin
      npc        = mtvec_ref;
      mepc_ref   = pc;
      mcause_ref = `EXU_CAUSE_ECALL;
    end else if (sop == exu_pkg::SYS_MRET) begin
      npc            = mepc_ref;
      mstatus_ref[3] = mstatus_ref[7];
      mstatus_ref[7] = 1'b1;
    end
    expect_wb(5'd9, 1'b0, 1'b0, 32'h0, npc, sop == exu_pkg::SYS_EBREAK);
    send_op(exu_pkg::OP_SYSTEM, exu_pkg::ADD, sop, 32'h0, 32'h0, 32'h0, pc, 5'd9, 12'h0);
  endtask

  // ============================================================
  // Credit tracking and writeback monitor.
  // ============================================================
  always @(negedge clk) begin
    if (!rst && op_credit_o) ret_cnt++;
  end

  always @(posedge clk) begin : monitor
    wb_rec_t e;
    int      pend;
    if (rst) begin
      owed = 0;
      wb_credit_i <= 1'b0;
    end else begin
      if (wb_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("A writeback record arrived while none was expected");
          stop_run();
        end
        e = exp_q.pop_front();
        check_val("wb_rd_o", wb_rd_o, e.rd);
        check_val("wb_wen_o", wb_wen_o, e.wen);
        check_val("wb_npc_o", wb_npc_o, e.npc);
        check_val("wb_ebreak_o", wb_ebreak_o, e.ebreak);
        if (e.care) check_val("wb_data_o", wb_data_o, e.data);
        got_cnt++;
      end
      pend = owed + (wb_valid_o ? 1 : 0);
      if (!hold_credits && pend > 0) begin
        wb_credit_i <= 1'b1;       // One credit back per cycle.
        pend--;
      end else begin
        wb_credit_i <= 1'b0;
      end
      owed = pend;
    end
  end

  initial begin
    repeat (WDOG_TICKS) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WDOG_TICKS);
    stop_run();
  end

  // ============================================================
  // Tests.
  // ============================================================
  task automatic test_reset();
    int ret0;
    @(posedge clk);
    check_val("wb_valid_o", wb_valid_o, 1'b0);
    check_val("op_credit_o", op_credit_o, 1'b0);
    ret0 = ret_cnt;
    repeat (4) @(posedge clk);
    check_val("op_credit_o pulses while idle", ret_cnt - ret0, 0);
    for (int i = 0; i < `EXU_IN_CREDITS; i++) run_alu(exu_pkg::ADD, i, 32'd100, 5'(i + 1));
    wait_idle();
    check_val("op_credit_o pulses after burst", ret_cnt - ret0, `EXU_IN_CREDITS);
  endtask

  task automatic test_alu();
    exu_pkg::alu_op_e op;
    logic [31:0]      r;
    logic [4:0]       rd;
    for (int i = 0; i < 40; i++) begin
      r  = next_rand();
      op = exu_pkg::alu_op_e'(4'(r % 12));
      r  = next_rand();
      rd = (i % 8 == 0) ? 5'd0 : r[4:0];
      run_alu(op, next_rand(), next_rand(), rd);
    end
    wait_idle();
  endtask

  task automatic test_branch();
    exu_pkg::alu_op_e kinds [6];
    logic [31:0]      lhs [3];
    logic [31:0]      rhs [3];
    kinds = '{exu_pkg::SUB, exu_pkg::XOR, exu_pkg::SLT, exu_pkg::SGE, exu_pkg::SLTU,
              exu_pkg::SGEU};
    lhs   = '{32'd7, 32'hFFFF_FFF0, 32'h10};  // Equal, less, greater (signed).
    rhs   = '{32'd7, 32'h10, 32'hFFFF_FFF0};
    for (int k = 0; k < 6; k++) begin
      for (int j = 0; j < 3; j++) begin
        run_branch(kinds[k], lhs[j], rhs[j], j[0] ? 32'hFFFF_FFE0 : 32'h40);
      end
    end
    run_jump(exu_pkg::OP_JAL, 32'h0, 32'h80, 5'd1);
    run_jump(exu_pkg::OP_JALR, 32'h2001, 32'h10, 5'd2);
    run_jump(exu_pkg::OP_JAL, 32'h0, 32'hFFFF_FF00, 5'd0);
    wait_idle();
  endtask

  task automatic test_memory();
    mem_access(1'b1, 32'h0, 32'h10, next_rand(), 5'd3);
    mem_access(1'b1, 32'h20, 32'h4, next_rand(), 5'd3);
    mem_access(1'b1, 32'hF0, 32'hC, next_rand(), 5'd3);     // Last word.
    mem_access(1'b1, 32'h0, 32'h8, next_rand(), 5'd3);
    mem_access(1'b1, 32'h100, 32'h8, next_rand(), 5'd3);    // Wraps onto word 2.
    mem_access(1'b1, 32'h10, 32'h0, next_rand(), 5'd3);     // Overwrites word 4.
    mem_access(1'b0, 32'h0, 32'h10, 32'h0, 5'd6);
    mem_access(1'b0, 32'h20, 32'h4, 32'h0, 5'd7);
    mem_access(1'b0, 32'h80, 32'h7C, 32'h0, 5'd8);
    mem_access(1'b0, 32'h0, 32'h8, 32'h0, 5'd9);
    mem_access(1'b0, 32'h200, 32'h8, 32'h0, 5'd0);
    wait_idle();
  endtask

  task automatic test_csr();
    csr_access(exu_pkg::SYS_CSRRW, `EXU_CSR_MTVEC, 32'h100, 5'd1);
    csr_access(exu_pkg::SYS_CSRRW, `EXU_CSR_MTVEC, 32'h200, 5'd2);
    csr_access(exu_pkg::SYS_CSRRS, `EXU_CSR_MSTATUS, 32'h88, 5'd3);
    csr_access(exu_pkg::SYS_CSRRC, `EXU_CSR_MSTATUS, 32'h08, 5'd4);
    sys_event(exu_pkg::SYS_ECALL);
    csr_access(exu_pkg::SYS_CSRRS, `EXU_CSR_MEPC, 32'h0, 5'd5);
    csr_access(exu_pkg::SYS_CSRRS, `EXU_CSR_MCAUSE, 32'h0, 5'd6);
    sys_event(exu_pkg::SYS_MRET);
    csr_access(exu_pkg::SYS_CSRRW, `EXU_CSR_MSTATUS, 32'h0, 5'd0);
    sys_event(exu_pkg::SYS_MRET);                                    // MPIE was clear.
    csr_access(exu_pkg::SYS_CSRRS, `EXU_CSR_MSTATUS, 32'h0, 5'd7);
    csr_access(exu_pkg::SYS_CSRRW, 12'h7C0, 32'h55, 5'd8);
    csr_access(exu_pkg::SYS_CSRRS, 12'h7C0, 32'h0, 5'd8);
    sys_event(exu_pkg::SYS_EBREAK);
    wait_idle();
  endtask

  task automatic test_backpressure();
    int          got0;
    int          sent0;
    int          ret0;
    logic [31:0] r;
    repeat (3) @(posedge clk);
    @(negedge clk);
    hold_credits = 1'b1;
    got0  = got_cnt;
    sent0 = sent_cnt;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          r = next_rand();
          run_alu(exu_pkg::alu_op_e'(4'(r % 12)), next_rand(), next_rand(), 5'(i + 10));
        end
        end_ops();
      end
      begin
        repeat (40) @(posedge clk);
        check_val("results while credits are held", got_cnt - got0, `EXU_OUT_CREDITS);
        check_val("ops accepted while credits are held", sent_cnt - sent0,
                  `EXU_IN_CREDITS + `EXU_MEM_CREDITS + `EXU_OUT_CREDITS);
        ret0 = ret_cnt;
        repeat (10) @(posedge clk);
        check_val("op_credit_o pulses with all buffers full", ret_cnt - ret0, 0);
        @(negedge clk);
        hold_credits = 1'b0;
      end
    join
    wait_idle();
    check_val("results after credit release", got_cnt - got0, 8);
  endtask

  initial begin
    rst        = 1'b1;
    op_valid_i = 1'b0;
    op_class_i = exu_pkg::OP_ALU;
    alu_op_i   = exu_pkg::ADD;
    sys_op_i   = exu_pkg::SYS_CSRRW;
    src1_i     = '0;
    src2_i     = '0;
    imm_i      = '0;
    pc_i       = '0;
    rd_i       = '0;
    csr_addr_i = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_alu();
    test_branch();
    test_memory();
    test_csr();
    test_backpressure();
    repeat (4) @(posedge clk);
    if (exp_q.size() == 0 && got_cnt == sent_cnt) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Result count mismatch, %0d ops sent and %0d results seen", sent_cnt, got_cnt);
      stop_run();
    end
  end

endmodule

// File: list.f
+incdir+hw
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_csr_file.sv
hw/exu_execute.sv
hw/exu_mem_stage.sv
hw/exu_top.sv
sim/tb_exu_top.sv
